//--- Makefile
SRCS = stm_pkg.sv div_if.sv isqrt.sv udiv.sv stm_focus_operator.sv \
       stm_focus_top.sv tb_stm_focus.sv trans_pos.svh
BIN = obj_dir/Vtb_stm_focus

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) compile.f
	verilator --binary --timing -Wno-fatal --top-module tb_stm_focus \
	  --Mdir obj_dir -f compile.f

sim.log: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log

run: sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- compile.f
+incdir+.
stm_pkg.sv
div_if.sv
isqrt.sv
udiv.sv
stm_focus_operator.sv
stm_focus_top.sv
tb_stm_focus.sv

//--- div_if.sv
// Start/done link between a requester and one iterative divider.
// dividend and divisor must stay put from start until done;
// quotient and remainder hold from done until the next start.
`timescale 1ns/1ps
`default_nettype none

interface div_if;

  logic               start;  // one-cycle pulse
  stm_pkg::div_word_t dividend;
  stm_pkg::div_word_t divisor;
  stm_pkg::div_word_t quotient;
  stm_pkg::div_word_t remainder;
  logic               done;  // one-cycle pulse

  modport requester (
    output start, dividend, divisor,
    input  quotient, remainder, done
  );

  modport divider (
    input  start, dividend, divisor,
    output quotient, remainder, done
  );

endinterface

`default_nettype wire

//--- isqrt.sv
// Integer square root, floor(sqrt(operand)), two operand bits per cycle.
// done pulses 19 cycles after the start cycle. root holds until the next
// start. start is not accepted while a root is in progress.
`timescale 1ns/1ps
`default_nettype none

module isqrt (
  input  var logic            CLK,
  input  var logic            rst_n,
  input  var logic            start,
  input  var stm_pkg::dist2_t operand,
  output stm_pkg::dist_t      root,
  output logic                done
);

  localparam int STEPS = $bits(stm_pkg::dist_t);

  logic            busy;
  logic [4:0]      cnt;
  stm_pkg::dist2_t op_q;  // shifts out two bits per step
  logic [19:0]     rem;  // partial remainder, bounded by 2 * root
  logic [21:0]     rem_sh;
  logic [21:0]     trial;

  assign rem_sh = {rem, op_q[37:36]};
  assign trial  = {1'b0, root, 2'b01};  // 4 * root + 1

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= 5'(STEPS);
      end else if (busy) begin
        cnt <= cnt - 5'd1;
        if (cnt == 5'd1) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      op_q <= operand;
      rem  <= '0;
      root <= '0;
    end else if (busy) begin
      op_q <= op_q << 2;
      if (rem_sh >= trial) begin
        rem  <= 20'(rem_sh - trial);
        root <= {root[17:0], 1'b1};
      end else begin
        rem  <= rem_sh[19:0];
        root <= {root[17:0], 1'b0};
      end
    end
  end

  a_no_restart: assert property (@(posedge CLK) disable iff (!rst_n) start |-> !busy)
    else $error("isqrt started while busy");

endmodule

`default_nettype wire

//--- stm_focus_operator.sv
// Focus operator: phase and duty per transducer for one focal point.
// Transducers are handled one after another, so latency depends on the
// square root and divider iterations. done marks the end; the output
// banks switch as done falls. start outside idle is ignored.
// The cycle table is read live, so writes during a run take effect at once.
`timescale 1ns/1ps
`default_nettype none

module stm_focus_operator #(
  parameter int WIDTH = 13,
  parameter int DEPTH = 8
) (
  input  var logic                     CLK,
  input  var logic                     rst_n,
  input  var logic                     start,
  input  var stm_pkg::focus_word_t     focus,
  input  var stm_pkg::speed_t          sound_speed,
  output logic [$clog2(DEPTH)-1:0]     cycle_rd_addr,
  input  var logic [WIDTH-1:0]         cycle,
  input  var logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic [WIDTH-2:0]             duty,
  output logic [WIDTH-1:0]             phase,
  output logic                         done
);

  `include "trans_pos.svh"

  localparam int AW = $clog2(DEPTH);

  typedef enum logic [2:0] {
    st_idle, st_dist, st_root, st_speed, st_modulo, st_write, st_swap
  } state_t;

  state_t          state;
  logic [AW-1:0]   tr_idx;
  logic [1:0]      dist_ph;  // sub-step inside st_dist
  logic            sqrt_start;
  logic            sqrt_done;
  stm_pkg::dist_t  root;
  stm_pkg::coord_t fx, fy, fz;
  logic [3:0]      duty_shift;
  stm_pkg::coord_t dx, dy;
  logic [35:0]     dx2, dy2, dz2;
  stm_pkg::dist2_t d2;

  logic [WIDTH-2:0] duty_buf[DEPTH];  // shadow banks
  logic [WIDTH-1:0] phase_buf[DEPTH];
  logic [WIDTH-2:0] duty_q[DEPTH];  // visible banks
  logic [WIDTH-1:0] phase_q[DEPTH];

  div_if div_speed ();
  div_if div_cycle ();

  isqrt u_isqrt (
    .CLK,
    .rst_n,
    .start  (sqrt_start),
    .operand(d2),
    .root,
    .done   (sqrt_done)
  );

  udiv u_div_speed (.CLK, .rst_n, .bus(div_speed.divider));
  udiv u_div_cycle (.CLK, .rst_n, .bus(div_cycle.divider));

  assign cycle_rd_addr = tr_idx;
  assign duty          = duty_q[rd_addr];
  assign phase         = phase_q[rd_addr];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state           <= st_idle;
      tr_idx          <= '0;
      dist_ph         <= '0;
      sqrt_start      <= 1'b0;
      div_speed.start <= 1'b0;
      div_cycle.start <= 1'b0;
      done            <= 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
        duty_q[i]  <= '0;
        phase_q[i] <= '0;
      end
    end else begin
      sqrt_start      <= 1'b0;
      div_speed.start <= 1'b0;
      div_cycle.start <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            tr_idx  <= '0;
            dist_ph <= '0;
            state   <= st_dist;
          end
        end
        st_dist: begin
          dist_ph <= dist_ph + 2'd1;
          if (dist_ph == 2'd2) begin
            dist_ph    <= '0;
            sqrt_start <= 1'b1;  // d2 is valid next cycle
            state      <= st_root;
          end
        end
        st_root: begin
          if (sqrt_done) begin
            div_speed.start <= 1'b1;
            state           <= st_speed;
          end
        end
        st_speed: begin
          if (div_speed.done) begin
            div_cycle.start <= 1'b1;
            state           <= st_modulo;
          end
        end
        st_modulo: if (div_cycle.done) state <= st_write;
        st_write: begin
          if (tr_idx == AW'(DEPTH - 1)) begin
            done  <= 1'b1;
            state <= st_swap;
          end else begin
            tr_idx <= tr_idx + 1'b1;
            state  <= st_dist;
          end
        end
        st_swap: begin
          duty_q  <= duty_buf;
          phase_q <= phase_buf;
          done    <= 1'b0;
          state   <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    case (state)
      st_idle: begin
        if (start) begin
          fx         <= focus[17:0];
          fy         <= focus[35:18];
          fz         <= focus[53:36];
          duty_shift <= focus[57:54];
        end
      end
      st_dist: begin
        case (dist_ph)
          2'd0: begin
            dx <= fx - stm_pkg::coord_t'(TRANS_X[tr_idx]);
            dy <= fy - stm_pkg::coord_t'(TRANS_Y[tr_idx]);
          end
          2'd1: begin
            dx2 <= dx * dx;
            dy2 <= dy * dy;
            dz2 <= fz * fz;
          end
          default: begin
            d2 <= stm_pkg::dist2_t'(dx2) + stm_pkg::dist2_t'(dy2) + stm_pkg::dist2_t'(dz2);
          end
        endcase
      end
      st_root: begin
        if (sqrt_done) begin
          div_speed.dividend <= stm_pkg::div_word_t'(root) << stm_pkg::FRAC_BITS;
          div_speed.divisor  <= stm_pkg::div_word_t'(sound_speed);
        end
      end
      st_speed: begin
        if (div_speed.done) begin
          div_cycle.dividend <= div_speed.quotient;
          div_cycle.divisor  <= stm_pkg::div_word_t'(cycle);
        end
      end
      st_write: begin
        phase_buf[tr_idx] <= div_cycle.remainder[WIDTH-1:0];
        duty_buf[tr_idx]  <= cycle[WIDTH-1:1] >> duty_shift;
      end
      default: ;
    endcase
  end

  a_done_pulse: assert property (@(posedge CLK) disable iff (!rst_n) done |=> !done)
    else $error("done held longer than one cycle");

  // the position table only covers TRANS_NUM elements
  a_depth_fits: assert property (@(posedge CLK) DEPTH <= TRANS_NUM)
    else $error("DEPTH exceeds the position table");

endmodule

`default_nettype wire

//--- stm_focus_top.sv
// Focus top level: sequence memory, cycle table and index-change detect.
// A new idx gives a start pulse two cycles after it is sampled. Writing
// the same idx again does nothing. Both memories have no reset, so the
// cycle table must be written with nonzero cycles before the first start.
`timescale 1ns/1ps
`default_nettype none

module stm_focus_top #(
  parameter int WIDTH = 13,
  parameter int DEPTH = 8
) (
  input  var logic                                  CLK,
  input  var logic                                  rst_n,
  input  var logic [$clog2(stm_pkg::SEQ_DEPTH)-1:0] idx,
  input  var logic                                  focus_wr_en,
  input  var logic [$clog2(stm_pkg::SEQ_DEPTH)-1:0] focus_wr_addr,
  input  var stm_pkg::focus_word_t                  focus_wr_data,
  input  var logic                                  cycle_wr_en,
  input  var logic [$clog2(DEPTH)-1:0]              cycle_wr_addr,
  input  var logic [WIDTH-1:0]                      cycle_wr_data,
  input  var stm_pkg::speed_t                       sound_speed,
  input  var logic [$clog2(DEPTH)-1:0]              rd_addr,
  output logic [WIDTH-2:0]                          duty,
  output logic [WIDTH-1:0]                          phase,
  output logic                                      start,
  output logic                                      done
);

  localparam int IW = $clog2(stm_pkg::SEQ_DEPTH);

  stm_pkg::focus_word_t focus_mem[stm_pkg::SEQ_DEPTH];
  logic [WIDTH-1:0]     cycle_tbl[DEPTH];

  logic [IW-1:0]              idx_q;
  logic [IW-1:0]              idx_old;
  logic                       start_buf;
  logic [$clog2(DEPTH)-1:0]   cycle_rd_addr;

  always_ff @(posedge CLK) begin
    if (focus_wr_en) focus_mem[focus_wr_addr] <= focus_wr_data;
    if (cycle_wr_en) cycle_tbl[cycle_wr_addr] <= cycle_wr_data;
  end

  // change detect, start lands two edges after idx is sampled
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      idx_q     <= '0;
      idx_old   <= '0;
      start_buf <= 1'b0;
      start     <= 1'b0;
    end else begin
      idx_q     <= idx;
      idx_old   <= idx_q;
      start_buf <= idx_q != idx_old;
      start     <= start_buf;
    end
  end

  stm_focus_operator #(
    .WIDTH(WIDTH),
    .DEPTH(DEPTH)
  ) u_operator (
    .CLK,
    .rst_n,
    .start,
    .focus        (focus_mem[idx_q]),  // read at the index that fired start
    .sound_speed,
    .cycle_rd_addr,
    .cycle        (cycle_tbl[cycle_rd_addr]),
    .rd_addr,
    .duty,
    .phase,
    .done
  );

endmodule

`default_nettype wire

//--- stm_pkg.sv
// Widths and constants shared by the focus RTL and its testbench.
// Coordinates are in position units; the sound speed must use the same
// units scaled by 2^FRAC_BITS, or the phase has no physical meaning.
`default_nettype none

package stm_pkg;

  // stored focal point: x [17:0], y [35:18], z [53:36], duty shift [57:54]
  typedef logic [63:0] focus_word_t;

  typedef logic signed [17:0] coord_t;  // focal coordinate
  typedef logic [15:0] pos_t;  // transducer coordinate, never negative

  typedef logic [37:0] dist2_t;  // squared distance
  typedef logic [18:0] dist_t;  // square root of dist2_t

  typedef logic [47:0] div_word_t;  // divider operands and results
  typedef logic [31:0] speed_t;

  localparam int FRAC_BITS = 22;  // fixed-point scale of the distance
  localparam int SEQ_DEPTH = 16;  // focal points in the sequence memory

endpackage

`default_nettype wire

//--- tb_stm_focus.sv
// Testbench for stm_focus_top applying a table of focal points in a loop.
// Expected phase and duty come from a behavioral model of the focus rules.
// Consecutive table indices must differ or no start is produced.
// The cycle table is written before the first index change.
`timescale 1ns/1ps
`default_nettype none

module tb_stm_focus;

  `include "trans_pos.svh"

  localparam int WIDTH      = 13;
  localparam int DEPTH      = 8;
  localparam int N_ENTRIES  = 9;
  localparam int DONE_LIMIT = 2000;  // cycles allowed per computation
  localparam int CYCLE_INIT[DEPTH] = '{5000, 4999, 4096, 8191, 3000, 1234, 6000, 7777};

  typedef struct packed {
    int x;
    int y;
    int z;
    int shift;
    int index;
    int speed;
    int ovr_addr;  // -1 leaves the cycle table alone
    int ovr_cycle;
  } entry_t;

  logic                 CLK;
  logic                 rst_n;
  logic [3:0]           idx;
  logic                 focus_wr_en;
  logic [3:0]           focus_wr_addr;
  stm_pkg::focus_word_t focus_wr_data;
  logic                 cycle_wr_en;
  logic [2:0]           cycle_wr_addr;
  logic [WIDTH-1:0]     cycle_wr_data;
  stm_pkg::speed_t      sound_speed;
  logic [2:0]           rd_addr;
  logic [WIDTH-2:0]     duty;
  logic [WIDTH-1:0]     phase;
  logic                 start;
  logic                 done;

  entry_t table_q[N_ENTRIES];
  string  entry_name[N_ENTRIES];
  int     cycle_model[DEPTH];
  longint exp_phase[DEPTH];
  longint exp_duty[DEPTH];
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;
  int     test_err0;  // error count when the current test began

  stm_focus_top #(
    .WIDTH(WIDTH),
    .DEPTH(DEPTH)
  ) stm_focus_top_i (
    .CLK,
    .rst_n,
    .idx,
    .focus_wr_en,
    .focus_wr_addr,
    .focus_wr_data,
    .cycle_wr_en,
    .cycle_wr_addr,
    .cycle_wr_data,
    .sound_speed,
    .rd_addr,
    .duty,
    .phase,
    .start,
    .done
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    repeat ((N_ENTRIES + 2) * 2000) @(posedge CLK);
    $display("watchdog expired after %0d cycles, run did not complete",
             (N_ENTRIES + 2) * 2000);
    $display("test failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic set_entry(input int k, input string name, input int x, input int y,
                           input int z, input int shift, input int index,
                           input int speed, input int ovr_addr, input int ovr_cycle);
    table_q[k].x         = x;
    table_q[k].y         = y;
    table_q[k].z         = z;
    table_q[k].shift     = shift;
    table_q[k].index     = index;
    table_q[k].speed     = speed;
    table_q[k].ovr_addr  = ovr_addr;
    table_q[k].ovr_cycle = ovr_cycle;
    entry_name[k]        = name;
  endtask

  task automatic build_table();
    int rx;
    int ry;
    int rz;
    set_entry(0, "on axis", 150, 50, 1000, 0, 1, 1500, -1, 0);
    set_entry(1, "off axis", 800, -300, 2500, 3, 2, 1500, -1, 0);
    set_entry(2, "negative coords", -4000, -7000, -3000, 15, 3, 1480, -1, 0);
    set_entry(3, "cycle rewrite", 800, -300, 2500, 3, 4, 1500, 5, 999);
    set_entry(4, "speed change", 800, -300, 2500, 3, 5, 3430, -1, 0);
    set_entry(5, "far corner", 120000, -120000, 100000, 0, 9, 2000, -1, 0);
    for (int k = 6; k < N_ENTRIES; k++) begin
      rx = int'($urandom % 100001) - 50000;
      ry = int'($urandom % 100001) - 50000;
      rz = int'($urandom % 100001) - 50000;
      set_entry(k, $sformatf("random %0d", k - 5), rx, ry, rz, int'($urandom % 16), k,
                500 + int'($urandom % 200000), -1, 0);
    end
  endtask

  // x [17:0], y [35:18], z [53:36], shift [57:54]
  function automatic stm_pkg::focus_word_t pack_focus(input int x, input int y,
                                                      input int z, input int shift);
    stm_pkg::focus_word_t w;
    w        = '0;
    w[17:0]  = x[17:0];
    w[35:18] = y[17:0];
    w[53:36] = z[17:0];
    w[57:54] = shift[3:0];
    return w;
  endfunction

  function automatic longint floor_sqrt(input longint n);
    longint r;
    longint t;
    r = 0;
    for (int b = 19; b >= 0; b--) begin
      t = r | (longint'(1) << b);
      if (t * t <= n) r = t;
    end
    return r;
  endfunction

  task automatic predict(input entry_t e);
    longint dx;
    longint dy;
    longint dz;
    longint q;
    for (int i = 0; i < DEPTH; i++) begin
      dx = longint'(e.x) - longint'(TRANS_X[i]);
      dy = longint'(e.y) - longint'(TRANS_Y[i]);
      dz = longint'(e.z);
      q  = (floor_sqrt(dx * dx + dy * dy + dz * dz) << stm_pkg::FRAC_BITS) / e.speed;
      exp_phase[i] = q % cycle_model[i];
      exp_duty[i]  = (cycle_model[i] >> 1) >> e.shift;
    end
  endtask

  task automatic write_focus(input int addr, input stm_pkg::focus_word_t w);
    @(negedge CLK);
    focus_wr_en   = 1'b1;
    focus_wr_addr = 4'(addr);
    focus_wr_data = w;
    @(negedge CLK);
    focus_wr_en = 1'b0;
  endtask

  task automatic write_cycle(input int addr, input int value);
    @(negedge CLK);
    cycle_wr_en   = 1'b1;
    cycle_wr_addr = 3'(addr);
    cycle_wr_data = WIDTH'(value);
    @(negedge CLK);
    cycle_wr_en       = 1'b0;
    cycle_model[addr] = value;
  endtask

  task automatic check_banks();
    for (int i = 0; i < DEPTH; i++) begin
      @(negedge CLK);
      rd_addr = 3'(i);
      @(posedge CLK);  // read port settled since the falling edge
      check_value($sformatf("phase[%0d]", i), 64'(phase), exp_phase[i]);
      check_value($sformatf("duty[%0d]", i), 64'(duty), exp_duty[i]);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_err0) begin
      tests_failed++;
      $display("[%0d] %s: %0d error(s)", tests_run, name, errors - test_err0);
    end else begin
      $display("[%0d] %s: ok", tests_run, name);
    end
    test_err0 = errors;
  endtask

  task automatic run_entry(input int k);
    entry_t e;
    int     n_start;
    int     c;
    bit     got_done;
    e        = table_q[k];
    n_start  = 0;
    got_done = 1'b0;
    write_focus(e.index, pack_focus(e.x, e.y, e.z, e.shift));
    if (e.ovr_addr >= 0) write_cycle(e.ovr_addr, e.ovr_cycle);
    predict(e);
    @(negedge CLK);
    sound_speed = stm_pkg::speed_t'(e.speed);
    idx         = 4'(e.index);
    for (c = 0; c < DONE_LIMIT && !got_done; c++) begin
      @(negedge CLK);
      if (start) n_start++;
      if (done) got_done = 1'b1;
    end
    if (!got_done) begin
      errors++;
      $display("done never arrived within %0d cycles for %s", DONE_LIMIT, entry_name[k]);
    end else begin
      check_value("start pulses", 64'(n_start), 64'd1);
      check_banks();  // banks swap on the edge after done
    end
    finish_test(entry_name[k]);
  endtask

  // same idx again must not restart the operator
  task automatic check_same_idx();
    int n_start;
    n_start = 0;
    @(negedge CLK);
    idx = 4'(table_q[N_ENTRIES-1].index);
    repeat (500) begin
      @(negedge CLK);
      if (start) n_start++;
    end
    check_value("start pulses", 64'(n_start), 64'd0);
    check_banks();
    finish_test("same idx again");
  endtask

  initial begin
    rst_n         = 1'b0;
    idx           = '0;
    focus_wr_en   = 1'b0;
    focus_wr_addr = '0;
    focus_wr_data = '0;
    cycle_wr_en   = 1'b0;
    cycle_wr_addr = '0;
    cycle_wr_data = '0;
    sound_speed   = 32'd1500;
    rd_addr       = '0;
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err0     = 0;
    void'($urandom(97297));
    build_table();

    repeat (16) begin
      @(negedge CLK);
      check_value("start", 64'(start), 64'd0);
      check_value("done", 64'(done), 64'd0);
    end
    rst_n = 1'b1;
    for (int i = 0; i < DEPTH; i++) write_cycle(i, CYCLE_INIT[i]);
    repeat (20) begin
      @(negedge CLK);
      check_value("start", 64'(start), 64'd0);
      check_value("done", 64'(done), 64'd0);
    end
    for (int i = 0; i < DEPTH; i++) begin
      exp_phase[i] = 0;
      exp_duty[i]  = 0;
    end
    check_banks();
    finish_test("reset and idle");

    for (int k = 0; k < N_ENTRIES; k++) run_entry(k);
    check_same_idx();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- trans_pos.svh
// Transducer positions for a 4 x 2 grid at 100 unit pitch.
// Include inside a module body; the table entries become local parameters
// of that module. Index i sits at x = (i mod 4) * 100, y = (i div 4) * 100.

localparam int TRANS_NUM = 8;

localparam stm_pkg::pos_t TRANS_X[TRANS_NUM] = '{
  16'd0, 16'd100, 16'd200, 16'd300,
  16'd0, 16'd100, 16'd200, 16'd300
};

localparam stm_pkg::pos_t TRANS_Y[TRANS_NUM] = '{
  16'd0,   16'd0,   16'd0,   16'd0,
  16'd100, 16'd100, 16'd100, 16'd100
};

//--- udiv.sv
// Restoring unsigned divider, one quotient bit per cycle.
// Operands are latched at start, done pulses 48 cycles later.
// Divide by zero is not handled; the requester must avoid it.
`timescale 1ns/1ps
`default_nettype none

module udiv (
  input var logic CLK,
  input var logic rst_n,
  div_if.divider  bus
);

  localparam int N = $bits(stm_pkg::div_word_t);

  logic                     busy;
  logic [$clog2(N+1)-1:0]   cnt;
  stm_pkg::div_word_t       d_q;
  stm_pkg::div_word_t       q_q;  // dividend shifts out, quotient shifts in
  stm_pkg::div_word_t       r_q;
  logic [N:0]               r_sh;

  assign r_sh = {r_q, q_q[N-1]};

  assign bus.quotient  = q_q;
  assign bus.remainder = r_q;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      cnt      <= '0;
      bus.done <= 1'b0;
    end else begin
      bus.done <= 1'b0;
      if (bus.start) begin
        busy <= 1'b1;
        cnt  <= ($clog2(N+1))'(N);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == 1) begin
          busy     <= 1'b0;
          bus.done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (bus.start) begin
      d_q <= bus.divisor;
      q_q <= bus.dividend;
      r_q <= '0;
    end else if (busy) begin
      if (r_sh >= {1'b0, d_q}) begin
        r_q <= N'(r_sh - {1'b0, d_q});
        q_q <= {q_q[N-2:0], 1'b1};
      end else begin
        r_q <= r_sh[N-1:0];
        q_q <= {q_q[N-2:0], 1'b0};
      end
    end
  end

  a_divisor_nonzero: assert property (
    @(posedge CLK) disable iff (!rst_n) bus.start |-> bus.divisor != '0
  ) else $error("udiv started with zero divisor");

endmodule

`default_nettype wire
